// ==== all.f ====
src/muldiv_cfg_pkg.sv
src/muldiv_msg_pkg.sv
src/int_mul_iterative.sv
src/int_div_iterative.sv
src/muldiv_router.sv
src/imuldiv_top.sv
verif/imuldiv_assert.sv
verif/imuldiv_tb.sv

// ==== Bender.yml ====
package:
  name: imuldiv

sources:
  # packages first, then units, router and top
  - files:
      - src/muldiv_cfg_pkg.sv
      - src/muldiv_msg_pkg.sv
      - src/int_mul_iterative.sv
      - src/int_div_iterative.sv
      - src/muldiv_router.sv
      - src/imuldiv_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - verif/imuldiv_assert.sv
      - verif/imuldiv_tb.sv

// ==== verif/imuldiv_tb.sv ====
// testbench for the integer multiply/divide unit
// corner and random requests checked against a reference model queue
`timescale 1ns/100ps

module imuldiv_tb;

  localparam int clk_period = 40;
  localparam int reset_cycles = 10;
  localparam int n_corner = 5;
  localparam int n_rand = 40;
  localparam int n_dz = 8;
  localparam int n_order = 20;
  localparam int n_bp = 60;
  localparam int total_reqs = 4 * n_corner * n_corner + 2 * n_rand + 2 * n_dz
                              + 2 * n_order + n_bp;
  // at most 40 cycles per request, plus reset and slack
  localparam int watchdog_cycles = reset_cycles + 40 * total_reqs + 200;

  logic clk = 1'b0;
  logic reset;
  logic req_val;
  logic req_rdy;
  muldiv_msg_pkg::muldiv_req_t req_msg;
  logic resp_val;
  logic resp_rdy;
  muldiv_msg_pkg::muldiv_resp_t resp_msg;

  logic [15:0] lfsr = 16'd40631;
  // random resp_rdy stalls when set
  logic stall_mode = 1'b0;
  // expected results in request order
  logic [63:0] exp_q[$];
  int chk_errs = 0;
  int n_checked = 0;
  int test_mark = 0;
  int check_mark = 0;
  int n_pass = 0;
  int n_fail = 0;
  logic [31:0] corner_vals [n_corner] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                          32'h7fff_ffff};

  imuldiv_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  bind imuldiv_top imuldiv_assert assert0 (.*);

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------
  // random source and model
  // ------------------------------

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] model_result(input muldiv_msg_pkg::muldiv_req_t m);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [63:0] sprod;
    sa = m.a;
    sb = m.b;
    sprod = sa;
    case (m.fn)
      muldiv_msg_pkg::fn_mul: return sprod * sb;
      muldiv_msg_pkg::fn_mulu: return {32'h0, m.a} * {32'h0, m.b};
      muldiv_msg_pkg::fn_divu: begin
        if (m.b == '0) return {m.a, 32'hffff_ffff};
        return {m.a % m.b, m.a / m.b};
      end
      default: begin
        if (m.b == '0) return {m.a, 32'hffff_ffff};
        // overflow case has a defined answer
        if (m.a == 32'h8000_0000 && m.b == 32'hffff_ffff) return {32'h0, 32'h8000_0000};
        return {sa % sb, sa / sb};
      end
    endcase
  endfunction

  function automatic int total_errs();
    return chk_errs + int'(dut0.assert0.fail_cnt);
  endfunction

  // ------------------------------
  // drivers
  // ------------------------------

  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    if (stall_mode) begin
      take_bits(2, r);
      resp_rdy <= (r[1:0] != 2'b00);
    end else begin
      resp_rdy <= 1'b1;
    end
  endtask

  // hold the request until the edge that takes it
  task automatic send_req(input muldiv_msg_pkg::muldiv_fn_e fn, input logic [31:0] a,
                          input logic [31:0] b);
    muldiv_msg_pkg::muldiv_req_t m;
    m.fn = fn;
    m.a = a;
    m.b = b;
    req_val <= 1'b1;
    req_msg <= m;
    tick();
    while (!req_rdy) tick();
    req_val <= 1'b0;
  endtask

  task automatic send_random(input muldiv_msg_pkg::muldiv_fn_e fn);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sh;
    take_bits(32, a);
    take_bits(32, b);
    // narrow divisors give quotients of every size
    take_bits(5, sh);
    send_req(fn, a, b >> sh[4:0]);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) tick();
  endtask

  task automatic end_test(input string name);
    int errs;
    int done;
    @(negedge clk);
    errs = total_errs() - test_mark;
    done = n_checked - check_mark;
    $display("test %s: %0d responses checked, %0d errors", name, done, errs);
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    test_mark = total_errs();
    check_mark = n_checked;
    tick();
  endtask

  // ------------------------------
  // response checker, sampled mid-cycle
  // ------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("response transfer with no request outstanding");
          chk_errs++;
        end else begin
          n_checked++;
          resp_ok_a: assert (resp_msg.result == exp_q[0]) else begin
            $display("mismatch resp_msg: got %h expected %h", resp_msg.result, exp_q[0]);
            chk_errs++;
          end
          void'(exp_q.pop_front());
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(model_result(req_msg));
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    logic [31:0] a;
    logic [31:0] r;
    reset = 1'b1;
    req_val = 1'b0;
    req_msg = '0;
    resp_rdy = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    // reset state is checked by the bound assertions
    tick();
    tick();
    end_test("reset");

    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < n_corner; i++) begin
        for (int j = 0; j < n_corner; j++) begin
          send_req((f == 0) ? muldiv_msg_pkg::fn_mul : muldiv_msg_pkg::fn_mulu,
                   corner_vals[i], corner_vals[j]);
        end
      end
    end
    for (int i = 0; i < n_rand; i++) begin
      send_random((i % 2 == 0) ? muldiv_msg_pkg::fn_mul : muldiv_msg_pkg::fn_mulu);
    end
    wait_drain();
    end_test("multiply");

    // corners include 0x80000000 / -1 and zero divisors
    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < n_corner; i++) begin
        for (int j = 0; j < n_corner; j++) begin
          send_req((f == 0) ? muldiv_msg_pkg::fn_div : muldiv_msg_pkg::fn_divu,
                   corner_vals[i], corner_vals[j]);
        end
      end
    end
    for (int i = 0; i < n_rand; i++) begin
      send_random((i % 2 == 0) ? muldiv_msg_pkg::fn_div : muldiv_msg_pkg::fn_divu);
    end
    wait_drain();
    end_test("divide");

    for (int i = 0; i < n_dz; i++) begin
      take_bits(32, a);
      if (i == 0) a = 32'h8000_0000;
      send_req(muldiv_msg_pkg::fn_div, a, '0);
      send_req(muldiv_msg_pkg::fn_divu, a, '0);
    end
    wait_drain();
    end_test("divide by zero");

    // back to back pairs keep both units busy at once
    for (int i = 0; i < n_order; i++) begin
      send_random((i % 2 == 0) ? muldiv_msg_pkg::fn_mul : muldiv_msg_pkg::fn_mulu);
      send_random((i % 2 == 0) ? muldiv_msg_pkg::fn_divu : muldiv_msg_pkg::fn_div);
    end
    wait_drain();
    end_test("ordering");

    stall_mode = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      take_bits(2, r);
      send_random(muldiv_msg_pkg::muldiv_fn_e'(r[1:0]));
    end
    wait_drain();
    stall_mode = 1'b0;
    end_test("back-pressure");

    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && total_errs() == 0 && exp_q.size() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog sized from the request count
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: requests still outstanding after %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verif/imuldiv_assert.sv ====
// handshake and latency assertions for the multiply/divide unit
// bound to the top level and counts every failed property
`timescale 1ns/100ps

module imuldiv_assert (
  input logic                         clk,
  input logic                         reset,
  input logic                         req_val,
  input logic                         req_rdy,
  input muldiv_msg_pkg::muldiv_req_t  req_msg,
  input logic                         resp_val,
  input logic                         resp_rdy,
  input muldiv_msg_pkg::muldiv_resp_t resp_msg
);

  // running count of assertion failures
  int unsigned fail_cnt = 0;
  // requests accepted and not yet answered
  int pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
    end
  end

  // ------------------------------
  // reset state
  // ------------------------------

  reset_state_a: assert property (@(posedge clk)
      $fell(reset) |-> !resp_val && req_rdy)
    else begin
      fail_cnt++;
      $error("unit not idle in the first cycle after reset");
    end

  // ------------------------------
  // valid/ready rules
  // ------------------------------

  // a stalled request stays put until it is taken
  req_hold_a: assert property (@(posedge clk) disable iff (reset)
      req_val && !req_rdy |=> req_val && $stable(req_msg))
    else begin
      fail_cnt++;
      $error("request dropped or changed while stalled");
    end

  // a stalled response stays put until it is taken
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
      resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else begin
      fail_cnt++;
      $error("response dropped or changed while stalled");
    end

  // ------------------------------
  // latency
  // ------------------------------

  // nothing ahead in the queue, so the answer shows after num_iter + 1 cycles
  latency_a: assert property (@(posedge clk) disable iff (reset)
      req_val && req_rdy && pending == 0 |=>
        !resp_val [* muldiv_cfg_pkg::num_iter] ##1 resp_val)
    else begin
      fail_cnt++;
      $error("response valid did not rise at the fixed latency");
    end

endmodule

// ==== src/imuldiv_top.sv ====
// integer multiply/divide unit top level
// router in front of the iterative multiplier and divider
`timescale 1ns/100ps

module imuldiv_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req_msg,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp_msg
);

  // multiplier link
  logic mul_req_val;
  logic mul_req_rdy;
  muldiv_msg_pkg::muldiv_req_t mul_req_msg;
  logic mul_resp_val;
  logic mul_resp_rdy;
  muldiv_msg_pkg::muldiv_resp_t mul_resp_msg;

  // divider link
  logic div_req_val;
  logic div_req_rdy;
  muldiv_msg_pkg::muldiv_req_t div_req_msg;
  logic div_resp_val;
  logic div_resp_rdy;
  muldiv_msg_pkg::muldiv_resp_t div_resp_msg;

  muldiv_router router0 (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_msg      (req_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_msg     (resp_msg),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_req_msg  (mul_req_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp_msg (mul_resp_msg),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_req_msg  (div_req_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_resp_msg (div_resp_msg)
  );

  int_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (mul_req_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp_msg)
  );

  int_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (div_req_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp_msg)
  );

endmodule

// ==== src/muldiv_router.sv ====
// steers requests to the multiplier or divider by function code
// and returns responses in request order through a small order queue
`timescale 1ns/100ps

module muldiv_router (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req_msg,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp_msg,
  output logic                         mul_req_val,
  input  logic                         mul_req_rdy,
  output muldiv_msg_pkg::muldiv_req_t  mul_req_msg,
  input  logic                         mul_resp_val,
  output logic                         mul_resp_rdy,
  input  muldiv_msg_pkg::muldiv_resp_t mul_resp_msg,
  output logic                         div_req_val,
  input  logic                         div_req_rdy,
  output muldiv_msg_pkg::muldiv_req_t  div_req_msg,
  input  logic                         div_resp_val,
  output logic                         div_resp_rdy,
  input  muldiv_msg_pkg::muldiv_resp_t div_resp_msg
);

  // one entry per request in flight, set for the divider
  logic [muldiv_cfg_pkg::order_depth-1:0] order_q;
  logic [muldiv_cfg_pkg::order_ptr_width-1:0] wr_ptr;
  logic [muldiv_cfg_pkg::order_ptr_width-1:0] rd_ptr;
  logic [muldiv_cfg_pkg::order_cnt_width-1:0] order_cnt;

  logic is_div;
  logic q_full;
  logic q_empty;
  logic head_div;
  logic push;
  logic pop;

  assign q_full = (order_cnt == muldiv_cfg_pkg::order_depth);
  assign q_empty = (order_cnt == '0);
  assign head_div = order_q[rd_ptr];

  // ------------------------------
  // request steering
  // ------------------------------

  always_comb begin
    is_div = (req_msg.fn == muldiv_msg_pkg::fn_div) || (req_msg.fn == muldiv_msg_pkg::fn_divu);
    // take a request only with room to record its order
    req_rdy = !q_full && (is_div ? div_req_rdy : mul_req_rdy);
    mul_req_val = req_val && !q_full && !is_div;
    div_req_val = req_val && !q_full && is_div;
  end

  // both units see the same message, only one gets valid
  assign mul_req_msg = req_msg;
  assign div_req_msg = req_msg;

  // ------------------------------
  // response merge
  // ------------------------------

  // the queue head owns the output port
  // the other unit waits with its ready low
  always_comb begin
    resp_val = !q_empty && (head_div ? div_resp_val : mul_resp_val);
    resp_msg = head_div ? div_resp_msg : mul_resp_msg;
    mul_resp_rdy = !q_empty && !head_div && resp_rdy;
    div_resp_rdy = !q_empty && head_div && resp_rdy;
  end

  assign push = req_val && req_rdy;
  assign pop = resp_val && resp_rdy;

  // ------------------------------
  // order queue
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      order_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == muldiv_cfg_pkg::order_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == muldiv_cfg_pkg::order_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        order_cnt <= order_cnt + 1'b1;
      end else if (pop && !push) begin
        order_cnt <= order_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= is_div;
    end
  end

endmodule

// ==== src/int_div_iterative.sv ====
// iterative restoring divider, one quotient bit per cycle
// magnitudes are divided and signs are fixed up on the way out
`timescale 1ns/100ps

module int_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req_msg,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp_msg
);

  muldiv_cfg_pkg::unit_state_e state;
  logic [muldiv_cfg_pkg::cntr_width-1:0] cntr;

  // {remainder, quotient} working register and shifted divisor
  logic [muldiv_cfg_pkg::div_reg_width-1:0] a_reg;
  logic [muldiv_cfg_pkg::div_reg_width-1:0] b_reg;
  // sign and special-case flags captured at acceptance
  logic quo_neg_reg;
  logic rem_neg_reg;
  logic dz_reg;
  // raw dividend, returned as remainder on divide by zero
  logic [muldiv_cfg_pkg::data_width-1:0] dividend_reg;

  logic is_signed;
  logic a_sign;
  logic b_sign;
  logic [muldiv_cfg_pkg::data_width-1:0] a_mag;
  logic [muldiv_cfg_pkg::data_width-1:0] b_mag;
  logic [muldiv_cfg_pkg::div_reg_width-1:0] a_shift;
  logic [muldiv_cfg_pkg::div_reg_width-1:0] sub_out;
  logic [muldiv_cfg_pkg::div_reg_width-1:0] a_next;
  logic [muldiv_cfg_pkg::data_width-1:0] quot_mag;
  logic [muldiv_cfg_pkg::data_width-1:0] rem_mag;
  logic [muldiv_cfg_pkg::data_width-1:0] quot_out;
  logic [muldiv_cfg_pkg::data_width-1:0] rem_out;
  logic req_go;
  logic resp_go;

  assign req_rdy = (state == muldiv_cfg_pkg::st_idle);
  assign resp_val = (state == muldiv_cfg_pkg::st_done);
  assign req_go = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------
  // operand conditioning
  // ------------------------------

  always_comb begin
    is_signed = (req_msg.fn == muldiv_msg_pkg::fn_div);
    a_sign = is_signed && req_msg.a[muldiv_cfg_pkg::data_width-1];
    b_sign = is_signed && req_msg.b[muldiv_cfg_pkg::data_width-1];
    a_mag = a_sign ? -req_msg.a : req_msg.a;
    b_mag = b_sign ? -req_msg.b : req_msg.b;
  end

  // ------------------------------
  // shift, subtract, restore
  // ------------------------------

  always_comb begin
    a_shift = a_reg << 1;
    sub_out = a_shift - b_reg;
    // negative difference means the divisor did not fit
    // keep the shifted value and shift in a zero quotient bit
    if (sub_out[muldiv_cfg_pkg::div_reg_width-1]) begin
      a_next = {a_shift[muldiv_cfg_pkg::div_reg_width-1:1], 1'b0};
    end else begin
      a_next = {sub_out[muldiv_cfg_pkg::div_reg_width-1:1], 1'b1};
    end
  end

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_cfg_pkg::st_idle;
      cntr <= '0;
    end else begin
      case (state)
        muldiv_cfg_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_cfg_pkg::st_calc;
            cntr <= muldiv_cfg_pkg::cntr_init;
          end
        end
        muldiv_cfg_pkg::st_calc: begin
          if (cntr == '0) begin
            state <= muldiv_cfg_pkg::st_done;
          end else begin
            cntr <= cntr - 1'b1;
          end
        end
        muldiv_cfg_pkg::st_done: begin
          // hold the result until the response is taken
          if (resp_go) begin
            state <= muldiv_cfg_pkg::st_idle;
          end
        end
        default: state <= muldiv_cfg_pkg::st_idle;
      endcase
    end
  end

  // ------------------------------
  // datapath registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      // dividend magnitude in the low half
      a_reg <= {{(muldiv_cfg_pkg::div_reg_width - muldiv_cfg_pkg::data_width){1'b0}}, a_mag};
      // divisor magnitude lined up with the remainder half
      b_reg <= {1'b0, b_mag, {muldiv_cfg_pkg::data_width{1'b0}}};
      quo_neg_reg <= a_sign ^ b_sign;
      rem_neg_reg <= a_sign;
      dz_reg <= (req_msg.b == '0);
      dividend_reg <= req_msg.a;
    end else if (state == muldiv_cfg_pkg::st_calc) begin
      a_reg <= a_next;
    end
  end

  // ------------------------------
  // result and sign fix-up
  // ------------------------------

  always_comb begin
    quot_mag = a_reg[muldiv_cfg_pkg::data_width-1:0];
    rem_mag = a_reg[2*muldiv_cfg_pkg::data_width-1:muldiv_cfg_pkg::data_width];
    // remainder takes the sign of the dividend
    quot_out = quo_neg_reg ? -quot_mag : quot_mag;
    rem_out = rem_neg_reg ? -rem_mag : rem_mag;
    // divide by zero: all-ones quotient, dividend as remainder
    if (dz_reg) begin
      resp_msg.result = {dividend_reg, {muldiv_cfg_pkg::data_width{1'b1}}};
    end else begin
      resp_msg.result = {rem_out, quot_out};
    end
  end

endmodule

// ==== src/int_mul_iterative.sv ====
// iterative shift-and-add multiplier, one multiplier bit per cycle
// signed operands run on magnitudes and the product is negated at the end
`timescale 1ns/100ps

module int_mul_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req_msg,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp_msg
);

  muldiv_cfg_pkg::unit_state_e state;
  logic [muldiv_cfg_pkg::cntr_width-1:0] cntr;

  // datapath registers
  logic [muldiv_cfg_pkg::result_width-1:0] mcand_reg;
  logic [muldiv_cfg_pkg::data_width-1:0] mplier_reg;
  logic [muldiv_cfg_pkg::result_width-1:0] acc_reg;
  logic neg_reg;

  logic is_signed;
  logic [muldiv_cfg_pkg::data_width-1:0] a_mag;
  logic [muldiv_cfg_pkg::data_width-1:0] b_mag;
  logic [muldiv_cfg_pkg::result_width-1:0] acc_next;
  logic req_go;
  logic resp_go;

  assign req_rdy = (state == muldiv_cfg_pkg::st_idle);
  assign resp_val = (state == muldiv_cfg_pkg::st_done);
  assign req_go = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------
  // operand conditioning
  // ------------------------------

  always_comb begin
    is_signed = (req_msg.fn == muldiv_msg_pkg::fn_mul);
    // magnitude only when the operation is signed and the operand negative
    a_mag = (is_signed && req_msg.a[muldiv_cfg_pkg::data_width-1]) ? -req_msg.a : req_msg.a;
    b_mag = (is_signed && req_msg.b[muldiv_cfg_pkg::data_width-1]) ? -req_msg.b : req_msg.b;
    // add the shifted multiplicand under the current multiplier bit
    acc_next = mplier_reg[0] ? (acc_reg + mcand_reg) : acc_reg;
  end

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_cfg_pkg::st_idle;
      cntr <= '0;
    end else begin
      case (state)
        muldiv_cfg_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_cfg_pkg::st_calc;
            cntr <= muldiv_cfg_pkg::cntr_init;
          end
        end
        muldiv_cfg_pkg::st_calc: begin
          // last step runs with the counter at zero
          if (cntr == '0) begin
            state <= muldiv_cfg_pkg::st_done;
          end else begin
            cntr <= cntr - 1'b1;
          end
        end
        muldiv_cfg_pkg::st_done: begin
          if (resp_go) begin
            state <= muldiv_cfg_pkg::st_idle;
          end
        end
        default: state <= muldiv_cfg_pkg::st_idle;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg <= {{(muldiv_cfg_pkg::result_width - muldiv_cfg_pkg::data_width){1'b0}}, a_mag};
      mplier_reg <= b_mag;
      acc_reg <= '0;
      neg_reg <= is_signed && (req_msg.a[muldiv_cfg_pkg::data_width-1] ^
                               req_msg.b[muldiv_cfg_pkg::data_width-1]);
    end else if (state == muldiv_cfg_pkg::st_calc) begin
      acc_reg <= acc_next;
      mcand_reg <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // sign fix-up on the finished product
  assign resp_msg.result = neg_reg ? -acc_reg : acc_reg;

endmodule

// ==== src/muldiv_msg_pkg.sv ====
// message formats of the integer multiply/divide unit
// function codes plus request and response payloads

package muldiv_msg_pkg;

  // ------------------------------
  // function codes
  // ------------------------------

  // bit 1 picks the divider, bit 0 marks unsigned
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } muldiv_fn_e;

  // ------------------------------
  // request message
  // ------------------------------

  // 66 bits in total
  typedef struct packed {
    // operation select
    muldiv_fn_e fn;
    // multiplicand or dividend
    logic [muldiv_cfg_pkg::data_width-1:0] a;
    // multiplier or divisor
    logic [muldiv_cfg_pkg::data_width-1:0] b;
  } muldiv_req_t;

  // ------------------------------
  // response message
  // ------------------------------

  // multiply returns the full 64-bit product
  // divide returns {remainder, quotient}
  typedef struct packed {
    logic [muldiv_cfg_pkg::result_width-1:0] result;
  } muldiv_resp_t;

endpackage

// ==== src/muldiv_cfg_pkg.sv ====
// configuration for the integer multiply/divide unit
// operand and result widths, iteration count, order queue depth

package muldiv_cfg_pkg;

  // ------------------------------
  // datapath sizes
  // ------------------------------

  // operand width
  localparam int data_width = 32;
  // full product or {remainder, quotient}
  localparam int result_width = 2 * data_width;
  // divider working register, one extra bit for the subtract sign
  localparam int div_reg_width = 2 * data_width + 1;

  // ------------------------------
  // iteration control
  // ------------------------------

  // one result bit per cycle
  localparam int num_iter = data_width;
  localparam int cntr_width = $clog2(num_iter);
  // down-counter start value, last iteration runs at zero
  localparam logic [cntr_width-1:0] cntr_init = cntr_width'(num_iter - 1);

  // shared FSM encoding of both iterative units
  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } unit_state_e;

  // ------------------------------
  // router order queue
  // ------------------------------

  // one multiply and one divide in flight at most
  localparam int order_depth = 2;
  localparam int order_ptr_width = $clog2(order_depth);
  localparam int order_cnt_width = $clog2(order_depth + 1);

endpackage
